/* verilog/core_alu_ctl.sv */
package core_alu_ctl;

  // bit positions in the control word
  parameter int control_select_b0     = 0;
  parameter int control_select_b1     = 1;
  parameter int control_select_b2     = 2;
  parameter int control_clear_rhs     = 3;
  parameter int control_invert_rhs    = 4;
  parameter int control_clear_carry   = 5;
  parameter int control_inv_carry_in  = 6;
  parameter int control_inv_carry_out = 7;
  parameter int control_flags_rhs     = 8;   // bit-style n and v from operand
  parameter int control_adc_overflow  = 9;
  parameter int control_result_sign   = 10;
  parameter int control_result_zero   = 11;
  parameter int control_set_carry     = 12;

  parameter int control_width = 13;

  typedef logic [control_width-1:0] control_type;

  // values of the select field
  parameter logic [2:0] alu_lhs = 3'd0;
  parameter logic [2:0] alu_rhs = 3'd1;
  parameter logic [2:0] alu_adc = 3'd2;
  parameter logic [2:0] alu_and = 3'd3;
  parameter logic [2:0] alu_or  = 3'd4;
  parameter logic [2:0] alu_xor = 3'd5;
  parameter logic [2:0] alu_asl = 3'd6;   // left through carry
  parameter logic [2:0] alu_lsr = 3'd7;   // right through carry

endpackage

/* verilog/cpu_state_pkg.sv */
package cpu_state_pkg;

  import core_alu_ctl::*;

  typedef struct packed {
    logic n;
    logic v;
    logic one;   // always reads 1
    logic b;
    logic d;
    logic i;
    logic z;
    logic c;
  } status_flags;

  typedef union packed {
    status_flags f;
    logic [7:0]  raw;
  } status_reg;

  parameter logic [7:0] op_lda = 8'hA9;
  parameter logic [7:0] op_adc = 8'h69;
  parameter logic [7:0] op_sbc = 8'hE9;
  parameter logic [7:0] op_and = 8'h29;
  parameter logic [7:0] op_ora = 8'h09;
  parameter logic [7:0] op_eor = 8'h49;
  parameter logic [7:0] op_cmp = 8'hC9;
  parameter logic [7:0] op_bit = 8'h24;
  parameter logic [7:0] op_asl = 8'h0A;
  parameter logic [7:0] op_lsr = 8'h4A;
  parameter logic [7:0] op_rol = 8'h2A;
  parameter logic [7:0] op_ror = 8'h6A;
  parameter logic [7:0] op_clc = 8'h18;
  parameter logic [7:0] op_sec = 8'h38;
  parameter logic [7:0] op_plp = 8'h28;
  parameter logic [7:0] op_nop = 8'hEA;

  typedef struct packed {
    control_type control;
    logic        mask_p;
    logic        write_a;
    logic        load_p;
    logic [7:0]  operand;
    logic        valid;
  } decoded_op;

endpackage

/* verilog/core_alu.sv */
`timescale 1ns/10ps

module core_alu
  import core_alu_ctl::*;
  import cpu_state_pkg::*;
(
  input  control_type control,
  input  logic        mask_p,
  input  logic [7:0]  lhs,
  input  logic [7:0]  rhs,
  input  status_flags flags,
  output logic [7:0]  result,
  output status_flags new_flags
);

  logic [7:0] rhs_c;   // conditioned operand
  logic [2:0] select;
  logic       carry;

  assign select = {control[control_select_b2], control[control_select_b1],
                   control[control_select_b0]};

  always_comb
  begin
    new_flags = flags;

    rhs_c = rhs;
    if (control[control_clear_rhs])
      rhs_c = 8'h00;
    if (control[control_invert_rhs])
      rhs_c = ~rhs_c;

    carry = flags.c;
    if (control[control_clear_carry])
      carry = 1'b0;
    if (control[control_inv_carry_in])
      carry = ~carry;

    case (select)
      alu_lhs: result = lhs;
      alu_rhs: result = rhs_c;
      alu_adc: {carry, result} = {1'b0, lhs} + {1'b0, rhs_c} + {8'h00, carry};
      alu_and: result = lhs & rhs_c;
      alu_or:  result = lhs | rhs_c;
      alu_xor: result = lhs ^ rhs_c;
      alu_asl: {carry, result} = {lhs, carry};
      alu_lsr: {result, carry} = {carry, lhs};
      default: result = lhs;
    endcase

    if (mask_p)
    begin
      if (control[control_flags_rhs])
        new_flags.v = rhs[6];
      else if (control[control_adc_overflow])
        new_flags.v = (lhs[7] != result[7]) && (lhs[7] == rhs_c[7]);

      if (control[control_flags_rhs])
        new_flags.n = rhs[7];
      else if (control[control_result_sign])
        new_flags.n = result[7];

      if (control[control_result_zero])
        new_flags.z = (result == 8'h00);
    end

    if (control[control_inv_carry_out])
      carry = ~carry;

    if (mask_p && control[control_set_carry])
      new_flags.c = carry;
  end

endmodule

/* verilog/alu_op_decoder.sv */
`timescale 1ns/10ps

module alu_op_decoder
  import core_alu_ctl::*;
  import cpu_state_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       op_valid,
  input  logic [7:0] opcode,
  input  logic [7:0] operand,
  output decoded_op  dec
);

  localparam control_type one_bit   = control_type'(1);
  localparam control_type n_res     = one_bit << control_result_sign;
  localparam control_type z_res     = one_bit << control_result_zero;
  localparam control_type nz        = n_res | z_res;
  localparam control_type c_out     = one_bit << control_set_carry;
  localparam control_type v_add     = one_bit << control_adc_overflow;
  localparam control_type inv_rhs   = one_bit << control_invert_rhs;
  localparam control_type clr_c     = one_bit << control_clear_carry;
  localparam control_type inv_c     = one_bit << control_inv_carry_in;
  localparam control_type rhs_flags = one_bit << control_flags_rhs;

  decoded_op nxt;

  function automatic control_type sel(input logic [2:0] code);
    return control_type'(code) << control_select_b0;
  endfunction

  always_comb
  begin
    nxt         = '0;
    nxt.operand = operand;
    nxt.valid   = op_valid;
    nxt.mask_p  = 1'b1;
    nxt.write_a = 1'b1;

    case (opcode)
      op_lda: nxt.control = sel(alu_rhs) | nz;
      op_adc: nxt.control = sel(alu_adc) | nz | v_add | c_out;
      op_sbc: nxt.control = sel(alu_adc) | inv_rhs | nz | v_add | c_out;
      op_and: nxt.control = sel(alu_and) | nz;
      op_ora: nxt.control = sel(alu_or) | nz;
      op_eor: nxt.control = sel(alu_xor) | nz;
      op_asl: nxt.control = sel(alu_asl) | clr_c | nz | c_out;
      op_lsr: nxt.control = sel(alu_lsr) | clr_c | nz | c_out;
      op_rol: nxt.control = sel(alu_asl) | nz | c_out;   // old carry shifts in
      op_ror: nxt.control = sel(alu_lsr) | nz | c_out;
      op_cmp:
      begin
        nxt.control = sel(alu_adc) | inv_rhs | clr_c | inv_c | nz | c_out;
        nxt.write_a = 1'b0;
      end
      op_bit:
      begin
        nxt.control = sel(alu_and) | rhs_flags | z_res;
        nxt.write_a = 1'b0;
      end
      op_clc:
      begin
        nxt.control = sel(alu_lhs) | clr_c | c_out;
        nxt.write_a = 1'b0;
      end
      op_sec:
      begin
        nxt.control = sel(alu_lhs) | clr_c | inv_c | c_out;
        nxt.write_a = 1'b0;
      end
      op_plp:
      begin
        nxt.load_p  = 1'b1;
        nxt.mask_p  = 1'b0;
        nxt.write_a = 1'b0;
      end
      op_nop:
      begin
        nxt.mask_p  = 1'b0;
        nxt.write_a = 1'b0;
      end
      default:   // unknown opcodes act as nop
      begin
        nxt.mask_p  = 1'b0;
        nxt.write_a = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      dec <= '0;
    else
      dec <= nxt;
  end

endmodule

/* verilog/cpu_regs.sv */
`timescale 1ns/10ps

module cpu_regs
  import cpu_state_pkg::*;
#(
  parameter logic [7:0] a_reset = 8'h00,
  parameter logic [7:0] p_reset = 8'h20
)
(
  input  logic        clk,
  input  logic        arst_n,
  input  decoded_op   dec,
  input  logic [7:0]  result,
  input  status_flags new_flags,
  output logic [7:0]  a,
  output status_reg   p
);

  status_reg p_next;

  // raw byte for plp and alu flags otherwise
  always_comb
  begin
    if (dec.load_p)
      p_next.raw = dec.operand;
    else
      p_next.f = new_flags;
    p_next.f.one = 1'b1;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      a     <= a_reset;
      p.raw <= p_reset;
    end
    else if (dec.valid)
    begin
      if (dec.write_a)
        a <= result;
      p <= p_next;
    end
  end

endmodule

/* verilog/alu_exec_unit.sv */
`timescale 1ns/10ps

module alu_exec_unit
  import cpu_state_pkg::*;
#(
  parameter logic [7:0] a_reset = 8'h00,
  parameter logic [7:0] p_reset = 8'h20   // only the one bit
)
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       op_valid,
  input  logic [7:0] opcode,
  input  logic [7:0] operand,
  output logic [7:0] a,
  output logic [7:0] p,
  output logic       done
);

  decoded_op   dec;
  status_reg   p_reg;
  status_flags new_flags;
  logic [7:0]  result;

  alu_op_decoder i_alu_op_decoder (
    .clk      (clk),
    .arst_n   (arst_n),
    .op_valid (op_valid),
    .opcode   (opcode),
    .operand  (operand),
    .dec      (dec)
  );

  core_alu i_core_alu (
    .control   (dec.control),
    .mask_p    (dec.mask_p),
    .lhs       (a),
    .rhs       (dec.operand),
    .flags     (p_reg.f),
    .result    (result),
    .new_flags (new_flags)
  );

  cpu_regs #(
    .a_reset (a_reset),
    .p_reset (p_reset)
  ) i_cpu_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec       (dec),
    .result    (result),
    .new_flags (new_flags),
    .a         (a),
    .p         (p_reg)
  );

  assign p = p_reg.raw;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      done <= 1'b0;
    else
      done <= dec.valid;   // same edge as write-back
  end

endmodule

/* sim/alu_exec_asserts.sv */
`timescale 1ns/10ps

module alu_exec_asserts
(
  input logic       clk,
  input logic       arst_n,
  input logic       op_valid,
  input logic [7:0] p,
  input logic       done
);

  reset_done_low: assert property (@(posedge clk) !arst_n |-> !done)
    else $error("done high while reset is asserted");

  // decode edge plus write-back edge
  done_latency: assert property (@(posedge clk) disable iff (!arst_n)
    done == $past(op_valid, 2))
    else $error("done does not follow op_valid by two edges");

  p_one_bit: assert property (@(posedge clk) disable iff (!arst_n) p[5])
    else $error("status bit 5 is not set");

endmodule

bind alu_exec_unit alu_exec_asserts i_alu_exec_asserts (.*);

/* sim/alu_exec_tb.sv */
`timescale 1ns/10ps

module alu_exec_tb;

  localparam int max_cases      = 64;
  localparam int timeout_cycles = 20;

  logic       clk;
  logic       arst_n;
  logic       op_valid;
  logic [7:0] opcode;
  logic [7:0] operand;
  logic [7:0] a;
  logic [7:0] p;
  logic       done;

  int         case_id [max_cases];
  logic [7:0] case_op [max_cases];
  logic [7:0] case_arg [max_cases];
  logic [7:0] exp_a [max_cases];
  logic [7:0] exp_p [max_cases];
  int         num_cases;
  int         value_errors;
  int         other_errors;

  alu_exec_unit i_alu_exec_unit (
    .clk      (clk),
    .arst_n   (arst_n),
    .op_valid (op_valid),
    .opcode   (opcode),
    .operand  (operand),
    .a        (a),
    .p        (p),
    .done     (done)
  );

  always #10 clk = ~clk;

  task automatic load_cases;
    int         fd;
    int         n;
    int         idx;
    string      line;
    logic [7:0] op_v;
    logic [7:0] arg_v;
    logic [7:0] a_v;
    logic [7:0] p_v;
    fd = $fopen("sim/alu_cases.txt", "r");
    if (fd == 0)
    begin
      other_errors++;
      $display("could not open the case file sim/alu_cases.txt");
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#")   // skip column notes
      begin
        n = $sscanf(line, "%d %h %h %h %h", idx, op_v, arg_v, a_v, p_v);
        if (n == 5 && num_cases < max_cases)
        begin
          case_id[num_cases]  = idx;
          case_op[num_cases]  = op_v;
          case_arg[num_cases] = arg_v;
          exp_a[num_cases]    = a_v;
          exp_p[num_cases]    = p_v;
          num_cases++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_reset;
    arst_n   = 1'b0;
    op_valid = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  endtask

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    assert (actual === expected)
    else
    begin
      value_errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_case(input int k);
    check_value($sformatf("case %0d a", case_id[k]), exp_a[k], a);
    check_value($sformatf("case %0d p", case_id[k]), exp_p[k], p);
  endtask

  // one op at a time, wait for its done
  task automatic run_single(input int k);
    int wait_cycles;
    @(negedge clk);
    op_valid = 1'b1;
    opcode   = case_op[k];
    operand  = case_arg[k];
    @(negedge clk);
    op_valid    = 1'b0;
    wait_cycles = 0;
    do
    begin
      @(negedge clk);
      wait_cycles++;
    end
    while (!done && wait_cycles < timeout_cycles);
    if (!done)
    begin
      other_errors++;
      $display("no done pulse for case %0d within %0d cycles", case_id[k], timeout_cycles);
    end
    else
      check_case(k);
  endtask

  // a new op on every cycle, one check per done pulse
  task automatic run_chain;
    int sent;
    int seen;
    int idle;
    sent = 0;
    seen = 0;
    idle = 0;
    while (seen < num_cases && idle < timeout_cycles)
    begin
      @(negedge clk);
      if (done)
      begin
        check_case(seen);
        seen++;
        idle = 0;
      end
      else
        idle++;
      op_valid = (sent < num_cases);
      if (sent < num_cases)
      begin
        opcode  = case_op[sent];
        operand = case_arg[sent];
        sent++;
      end
    end
    op_valid = 1'b0;
    if (seen < num_cases)
    begin
      other_errors++;
      $display("back-to-back run stalled after %0d of %0d done pulses", seen, num_cases);
    end
  endtask

  initial
  begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    op_valid     = 1'b0;
    opcode       = 8'hEA;
    operand      = 8'h00;
    value_errors = 0;
    other_errors = 0;
    num_cases    = 0;
    load_cases();
    if (num_cases == 0)
    begin
      other_errors++;
      $display("no cases were read from the case file");
    end
    apply_reset();
    check_value("reset a", 8'h00, a);
    check_value("reset p", 8'h20, p);
    for (int k = 0; k < num_cases; k++)
      run_single(k);
    apply_reset();   // same sequence again, issued back to back
    check_value("second reset a", 8'h00, a);
    check_value("second reset p", 8'h20, p);
    run_chain();
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
    begin
      $display(">>> PASS");
    end
    else
    begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* sim/alu_cases.txt */
# index opcode operand expected_a expected_p, all hex except index, mnemonic ignored
# runs in order from a=00 p=20 after reset
0  a9 00 00 22  lda
1  a9 80 80 a0  lda
2  29 0f 00 22  and
3  09 f5 f5 a0  ora
4  49 f5 00 22  eor
5  38 00 00 23  sec
6  a9 50 50 21  lda
7  18 00 50 20  clc
8  69 50 a0 e0  adc
9  69 60 00 23  adc
10 e9 01 ff a0  sbc
11 e9 7f 7f 61  sbc
12 c9 7f 7f 63  cmp
13 c9 80 7f e0  cmp
14 0a 00 fe e0  asl
15 2a 00 fc e1  rol
16 6a 00 fe e0  ror
17 4a 00 7f 60  lsr
18 24 80 7f a2  bit
19 28 0d 7f 2d  plp
20 ea 33 7f 2d  nop
21 ff 12 7f 2d  unknown
22 18 00 7f 2c  clc
23 38 00 7f 2d  sec
24 69 00 80 ec  adc

/* verilog.f */
verilog/core_alu_ctl.sv
verilog/cpu_state_pkg.sv
verilog/core_alu.sv
verilog/alu_op_decoder.sv
verilog/cpu_regs.sv
verilog/alu_exec_unit.sv
sim/alu_exec_asserts.sv
sim/alu_exec_tb.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module alu_exec_tb -o alu_exec_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/alu_exec_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
